/* all.f */
+incdir+.
mipsPkg.sv
alu32Bit.sv
aluControl.sv
registerFile.sv
executeStage.sv
mipsCore.sv
tb_mipsCore.sv

/* alu32Bit.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module alu32Bit (
    input  mipsPkg::aluOpType               aluControl,     // Operation select
    input  logic signed [`DATA_WIDTH-1:0]   a,
    input  logic signed [`DATA_WIDTH-1:0]   b,
    output logic signed [`DATA_WIDTH-1:0]   aluResult,
    output logic                            zero            // High on zero result
);

    import mipsPkg::*;

    logic lessThan;                     // Signed a < b

    // Both operands declared signed, so compare is signed
    assign lessThan = (a < b);

    //////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////

    always_comb begin
        case (aluControl)
            aluAdd: begin
                aluResult = a + b;
            end
            aluSub: begin
                aluResult = a - b;
            end
            aluMul: begin
                aluResult = a * b;      // Upper word dropped
            end
            aluSll: begin
                // Shift amount sits in a[10:6], b is the value shifted
                aluResult = b << a[`SHAMT_MSB:`SHAMT_LSB];
            end
            aluSrl: begin
                // Logical, zeros in from the top
                aluResult = $signed($unsigned(b) >> a[`SHAMT_MSB:`SHAMT_LSB]);
            end
            aluAnd: begin
                aluResult = a & b;
            end
            aluOr: begin
                aluResult = a | b;
            end
            aluXor: begin
                aluResult = a ^ b;
            end
            aluNor: begin
                aluResult = ~(a | b);
            end
            aluSlt: begin
                aluResult = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            end
            default: begin
                aluResult = '0;         // aluNone and unused codes
            end
        endcase
    end

    // Zero flag
    assign zero = (aluResult == '0);

endmodule

/* aluControl.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module aluControl (
    input  logic [`DATA_WIDTH-1:0]      instruction,
    output mipsPkg::aluOpType           aluOp,
    output mipsPkg::srcBType            srcB,
    output logic                        signExtend,     // Immediate sign extension
    output logic                        shiftOp,        // Operand A takes instruction
    output logic                        regWrite,
    output logic [`REG_ADDR_WIDTH-1:0]  destReg,
    output logic                        illegal
);

    import mipsPkg::*;

    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`FUNCT_WIDTH-1:0]    funct;
    logic [`REG_ADDR_WIDTH-1:0] rtField;
    logic [`REG_ADDR_WIDTH-1:0] rdField;

    // Field split
    assign opcode  = instruction[`OPCODE_LSB +: `OPCODE_WIDTH];
    assign funct   = instruction[`FUNCT_LSB +: `FUNCT_WIDTH];
    assign rtField = instruction[`RT_LSB +: `REG_ADDR_WIDTH];
    assign rdField = instruction[`RD_LSB +: `REG_ADDR_WIDTH];

    //////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////

    always_comb begin
        // Defaults for an R-type register op
        aluOp      = aluNone;
        srcB       = srcReg;
        signExtend = 1'b0;
        shiftOp    = 1'b0;
        regWrite   = 1'b1;
        destReg    = rdField;
        illegal    = 1'b0;

        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD: aluOp = aluAdd;
                    `FN_SUB: aluOp = aluSub;
                    `FN_AND: aluOp = aluAnd;
                    `FN_OR:  aluOp = aluOr;
                    `FN_XOR: aluOp = aluXor;
                    `FN_NOR: aluOp = aluNor;
                    `FN_SLT: aluOp = aluSlt;
                    `FN_SLL: begin
                        aluOp   = aluSll;
                        shiftOp = 1'b1;         // shamt via operand A
                    end
                    `FN_SRL: begin
                        aluOp   = aluSrl;
                        shiftOp = 1'b1;
                    end
                    default: begin
                        regWrite = 1'b0;        // Unknown funct
                        illegal  = 1'b1;
                    end
                endcase
            end
            `OP_SPECIAL2: begin
                if (funct == `FN_MUL) begin
                    aluOp = aluMul;
                end else begin
                    regWrite = 1'b0;
                    illegal  = 1'b1;
                end
            end
            // I-type, destination is rt
            `OP_ADDI: begin
                aluOp      = aluAdd;
                srcB       = srcImm;
                signExtend = 1'b1;
                destReg    = rtField;
            end
            `OP_SLTI: begin
                aluOp      = aluSlt;
                srcB       = srcImm;
                signExtend = 1'b1;
                destReg    = rtField;
            end
            `OP_ANDI: begin
                aluOp   = aluAnd;
                srcB    = srcImm;               // Zero extended
                destReg = rtField;
            end
            `OP_ORI: begin
                aluOp   = aluOr;
                srcB    = srcImm;
                destReg = rtField;
            end
            `OP_XORI: begin
                aluOp   = aluXor;
                srcB    = srcImm;
                destReg = rtField;
            end
            default: begin
                regWrite = 1'b0;                // Unknown opcode
                illegal  = 1'b1;
            end
        endcase
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module executeStage (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        instrValid,
    input  logic [`DATA_WIDTH-1:0]      instruction,
    input  mipsPkg::aluOpType           aluOp,
    input  mipsPkg::srcBType            srcB,
    input  logic                        signExtend,
    input  logic                        shiftOp,
    input  logic                        regWrite,
    input  logic                        illegalIn,
    input  logic [`REG_ADDR_WIDTH-1:0]  destRegIn,
    input  logic [`DATA_WIDTH-1:0]      rsData,
    input  logic [`DATA_WIDTH-1:0]      rtData,
    output logic                        resultValid,
    output logic                        illegal,
    output logic                        zero,
    output logic [`DATA_WIDTH-1:0]      result,
    output logic [`REG_ADDR_WIDTH-1:0]  destReg,
    output logic                        writeEnable,
    output logic [`REG_ADDR_WIDTH-1:0]  writeAddr,
    output logic [`DATA_WIDTH-1:0]      writeData
);

    import mipsPkg::*;

    logic [`IMM_WIDTH-1:0]  imm;
    logic [`DATA_WIDTH-1:0] immExt;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   aluZero;

    //////////////////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////////////////

    assign imm    = instruction[`IMM_WIDTH-1:0];
    assign immExt = signExtend ? {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm}
                               : {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm};

    // Shifts hand the whole word to A so the ALU finds shamt
    assign operandA = shiftOp ? instruction : rsData;
    assign operandB = (srcB == srcImm) ? immExt : rtData;

    alu32Bit alu32Bit_inst (
        .aluControl (aluOp),
        .a          (operandA),
        .b          (operandB),
        .aluResult  (aluResult),
        .zero       (aluZero)
    );

    // Write port committed at the strobe edge
    assign writeEnable = instrValid & regWrite;
    assign writeAddr   = destRegIn;
    assign writeData   = aluResult;

    //////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
            zero        <= 1'b0;
            result      <= '0;
            destReg     <= '0;
        end else begin
            resultValid <= instrValid;                  // One-cycle pulse
            illegal     <= instrValid & illegalIn;
            if (instrValid) begin                       // Hold when idle
                result  <= aluResult;
                zero    <= aluZero;
                destReg <= destRegIn;
            end
        end
    end

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsCore (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        instrValid,     // One-cycle strobe
    input  logic [`DATA_WIDTH-1:0]      instruction,
    output logic                        resultValid,
    output logic                        illegal,
    output logic                        zero,
    output logic [`DATA_WIDTH-1:0]      result,
    output logic [`REG_ADDR_WIDTH-1:0]  destReg
);

    import mipsPkg::*;

    // Decode outputs
    aluOpType                   aluOp;
    srcBType                    srcB;
    logic                       signExtend;
    logic                       shiftOp;
    logic                       regWrite;
    logic                       decIllegal;
    logic [`REG_ADDR_WIDTH-1:0] decDestReg;

    // Register file traffic
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    logic                       writeEnable;
    logic [`REG_ADDR_WIDTH-1:0] writeAddr;
    logic [`DATA_WIDTH-1:0]     writeData;

    //////////////////////////////////////////////////////////////
    // Decode and operand read
    //////////////////////////////////////////////////////////////

    aluControl aluControl_inst (
        .instruction (instruction),
        .aluOp       (aluOp),
        .srcB        (srcB),
        .signExtend  (signExtend),
        .shiftOp     (shiftOp),
        .regWrite    (regWrite),
        .destReg     (decDestReg),
        .illegal     (decIllegal)
    );

    registerFile registerFile_inst (
        .Clk         (Clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .readAddrA   (instruction[`RS_LSB +: `REG_ADDR_WIDTH]),   // rs
        .readAddrB   (instruction[`RT_LSB +: `REG_ADDR_WIDTH]),   // rt
        .writeData   (writeData),
        .readDataA   (rsData),
        .readDataB   (rtData)
    );

    //////////////////////////////////////////////////////////////
    // Execute and writeback
    //////////////////////////////////////////////////////////////

    executeStage executeStage_inst (
        .Clk         (Clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instruction (instruction),
        .aluOp       (aluOp),
        .srcB        (srcB),
        .signExtend  (signExtend),
        .shiftOp     (shiftOp),
        .regWrite    (regWrite),
        .illegalIn   (decIllegal),
        .destRegIn   (decDestReg),
        .rsData      (rsData),
        .rtData      (rtData),
        .resultValid (resultValid),
        .illegal     (illegal),
        .zero        (zero),
        .result      (result),
        .destReg     (destReg),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

endmodule

/* mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////////////////
    // ALU operation select
    //////////////////////////////////////////////////////////////

    // Encodings sized to the 5-bit ALU control word
    typedef enum logic [4:0] {
        aluNone = 5'b00000,         // Result forced to 0
        aluAdd  = 5'b00001,         // a + b
        aluSub  = 5'b00010,         // a - b
        aluMul  = 5'b00011,         // Low word of a * b
        aluSll  = 5'b00100,         // b << shamt
        aluSrl  = 5'b00101,         // Logical b >> shamt
        aluAnd  = 5'b00110,
        aluOr   = 5'b00111,
        aluXor  = 5'b01000,
        aluNor  = 5'b01101,
        aluSlt  = 5'b01110          // Signed compare giving 1 or 0
    } aluOpType;

    // Gaps in the encoding above are unused branch codes
    // Any of them reaching the ALU gives 0

    //////////////////////////////////////////////////////////////
    // Operand B source
    //////////////////////////////////////////////////////////////

    typedef enum logic {
        srcReg = 1'b0,              // rt read data
        srcImm = 1'b1               // Extended immediate
    } srcBType;

endpackage

/* mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

//////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////
`define DATA_WIDTH      32          // Data word
`define REG_ADDR_WIDTH  5           // Register index
`define REG_COUNT       32          // Entries in register file
`define IMM_WIDTH       16          // I-type immediate

// Instruction field positions
`define OPCODE_LSB      26
`define OPCODE_WIDTH    6
`define FUNCT_LSB       0
`define FUNCT_WIDTH     6
`define RS_LSB          21
`define RT_LSB          16
`define RD_LSB          11
`define SHAMT_LSB       6           // Shift amount, read by ALU from operand A
`define SHAMT_MSB       10

//////////////////////////////////////////////////////////////
// Major opcodes
//////////////////////////////////////////////////////////////
`define OP_RTYPE        6'h00
`define OP_SPECIAL2     6'h1c       // mul lives here
`define OP_ADDI         6'h08
`define OP_SLTI         6'h0a
`define OP_ANDI         6'h0c
`define OP_ORI          6'h0d
`define OP_XORI         6'h0e

// Funct codes
`define FN_SLL          6'h00
`define FN_SRL          6'h02
`define FN_ADD          6'h20
`define FN_SUB          6'h22
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a
`define FN_MUL          6'h02       // Under SPECIAL2 only

`endif

/* registerFile.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module registerFile (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0]  writeAddr,
    input  logic [`REG_ADDR_WIDTH-1:0]  readAddrA,      // rs
    input  logic [`REG_ADDR_WIDTH-1:0]  readAddrB,      // rt
    input  logic [`DATA_WIDTH-1:0]      writeData,
    output logic [`DATA_WIDTH-1:0]      readDataA,
    output logic [`DATA_WIDTH-1:0]      readDataB
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    //////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;       // r0 never written
        end
    end

    //////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////

    // Plain array reads, value written at an edge is visible right after it
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mipsCore -f all.f -o simv

simOut=$(./obj_dir/simv)
echo "$simOut"

if echo "$simOut" | grep -q "^Everything OK$"; then
    exit 0
else
    exit 1
fi

/* tb_mipsCore.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mipsCore;

    import mipsPkg::*;

    logic                       Clk;
    logic                       reset;
    logic                       instrValid;
    logic [`DATA_WIDTH-1:0]     instruction;
    logic                       resultValid;
    logic                       illegal;
    logic                       zero;
    logic [`DATA_WIDTH-1:0]     result;
    logic [`REG_ADDR_WIDTH-1:0] destReg;

    // Reference state
    logic [`DATA_WIDTH-1:0]     modelRegs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]     expResult;
    logic [`REG_ADDR_WIDTH-1:0] expDest;
    logic                       expIllegal;
    logic [31:0]                rngState;

    // Error tallies per kind
    int resultErrors;
    int zeroErrors;
    int regErrors;
    int flagErrors;
    int timeoutErrors;

    mipsCore mipsCore_inst (
        .Clk         (Clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instruction (instruction),
        .resultValid (resultValid),
        .illegal     (illegal),
        .zero        (zero),
        .result      (result),
        .destReg     (destReg)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;             // 20 ns period
    end

    //////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs, rt, rd,
                                          input logic [4:0] shamt);
        return {`OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Register-register ALU ops with mul under SPECIAL2
    function automatic logic [31:0] aluInstr(input logic [2:0] sel, input logic [4:0] rs, rt, rd);
        case (sel)
            3'd0:    return rType(`FN_ADD, rs, rt, rd, 5'd0);
            3'd1:    return rType(`FN_SUB, rs, rt, rd, 5'd0);
            3'd2:    return {`OP_SPECIAL2, rs, rt, rd, 5'd0, `FN_MUL};
            3'd3:    return rType(`FN_AND, rs, rt, rd, 5'd0);
            3'd4:    return rType(`FN_OR, rs, rt, rd, 5'd0);
            3'd5:    return rType(`FN_XOR, rs, rt, rd, 5'd0);
            3'd6:    return rType(`FN_NOR, rs, rt, rd, 5'd0);
            default: return rType(`FN_SLT, rs, rt, rd, 5'd0);
        endcase
    endfunction

    //////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////

    task automatic modelExec(input logic [31:0] instr);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] immS;
        logic [31:0] immZ;
        op         = instr[`OPCODE_LSB +: `OPCODE_WIDTH];
        fn         = instr[`FUNCT_LSB +: `FUNCT_WIDTH];
        rsVal      = modelRegs[instr[`RS_LSB +: `REG_ADDR_WIDTH]];
        rtVal      = modelRegs[instr[`RT_LSB +: `REG_ADDR_WIDTH]];
        immS       = {{16{instr[15]}}, instr[15:0]};
        immZ       = {16'h0000, instr[15:0]};
        expResult  = '0;                    // Illegal gives 0
        expDest    = instr[`RD_LSB +: `REG_ADDR_WIDTH];
        expIllegal = 1'b0;
        case (op)
            `OP_RTYPE: begin
                case (fn)
                    `FN_ADD: expResult = rsVal + rtVal;
                    `FN_SUB: expResult = rsVal - rtVal;
                    `FN_AND: expResult = rsVal & rtVal;
                    `FN_OR:  expResult = rsVal | rtVal;
                    `FN_XOR: expResult = rsVal ^ rtVal;
                    `FN_NOR: expResult = ~(rsVal | rtVal);
                    `FN_SLT: expResult = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
                    `FN_SLL: expResult = rtVal << instr[`SHAMT_MSB:`SHAMT_LSB];
                    `FN_SRL: expResult = rtVal >> instr[`SHAMT_MSB:`SHAMT_LSB];
                    default: expIllegal = 1'b1;
                endcase
            end
            `OP_SPECIAL2: begin
                if (fn == `FN_MUL) expResult = rsVal * rtVal;   // Low word
                else expIllegal = 1'b1;
            end
            `OP_ADDI: expResult = rsVal + immS;
            `OP_SLTI: expResult = ($signed(rsVal) < $signed(immS)) ? 32'd1 : 32'd0;
            `OP_ANDI: expResult = rsVal & immZ;
            `OP_ORI:  expResult = rsVal | immZ;
            `OP_XORI: expResult = rsVal ^ immZ;
            default:  expIllegal = 1'b1;
        endcase
        if (op != `OP_RTYPE && op != `OP_SPECIAL2) begin
            expDest = instr[`RT_LSB +: `REG_ADDR_WIDTH];    // I-type writes rt
        end
        if (!expIllegal && expDest != '0) modelRegs[expDest] = expResult;
    endtask

    //////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////

    task automatic checkResult(input string name, input logic [`DATA_WIDTH-1:0] expected,
                               input logic [`DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s result expected %h actual %h", name, expected, actual);
            resultErrors++;
        end
    endtask

    task automatic checkZero(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s zero expected %b actual %b", name, expected, actual);
            zeroErrors++;
        end
    endtask

    task automatic checkReg(input string name, input logic [`REG_ADDR_WIDTH-1:0] expected,
                            input logic [`REG_ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s destReg expected %0d actual %0d", name, expected, actual);
            regErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s flag expected %b actual %b", name, expected, actual);
            flagErrors++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Drive and collect
    //////////////////////////////////////////////////////////////

    task automatic waitResult(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 10) begin
            if (resultValid === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge Clk);
                #2;
                cycles++;
            end
        end
        if (!seen) begin
            $display("Timeout: the result pulse never came within 10 cycles");
            timeoutErrors++;
        end
    endtask

    // Leaves instrValid high for the caller to drop or strobe again
    task automatic driveInstr(input logic [31:0] instr);
        instruction = instr;
        instrValid  = 1'b1;
        modelExec(instr);                   // Reads before the write
        @(posedge Clk);
        #2;
    endtask

    task automatic checkOutputs(input string name);
        logic seen;
        waitResult(seen);
        if (seen) begin
            checkResult(name, expResult, result);
            checkZero(name, (expResult == '0), zero);
            checkFlag(name, expIllegal, illegal);
            if (!expIllegal) checkReg(name, expDest, destReg);
        end
    endtask

    task automatic runOne(input logic [31:0] instr, input string name);
        driveInstr(instr);
        instrValid = 1'b0;
        checkOutputs(name);
    endtask

    task automatic readAllRegs();
        for (int j = 0; j < `REG_COUNT; j++) begin
            // or rd=0 with rt=0 returns rs and writes nothing
            runOne(rType(`FN_OR, 5'(j), 5'd0, 5'd0, 5'd0), $sformatf("readback r%0d", j));
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] instr;
        logic [15:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  prevDest;
        logic [5:0]  op;
        logic [5:0]  fn;
        int          total;

        rngState      = 32'd40455;
        resultErrors  = 0;
        zeroErrors    = 0;
        regErrors     = 0;
        flagErrors    = 0;
        timeoutErrors = 0;
        reset         = 1'b1;
        instrValid    = 1'b0;
        instruction   = '0;
        for (int j = 0; j < `REG_COUNT; j++) modelRegs[j] = '0;

        repeat (8) @(posedge Clk);
        #2;
        reset = 1'b0;

        // 1. Quiet after reset then load every register
        checkResult("after reset", '0, result);
        checkZero("after reset", 1'b0, zero);
        checkReg("after reset", '0, destReg);
        for (int j = 0; j < 4; j++) begin
            @(posedge Clk);
            #2;
            checkFlag("idle resultValid", 1'b0, resultValid);
            checkFlag("idle illegal", 1'b0, illegal);
        end
        for (int j = 1; j < `REG_COUNT; j++) begin
            r   = nextRand();
            imm = r[15:0];
            if (j % 2 == 0) imm[15] = 1'b1;             // Force a negative immediate
            runOne(iType(`OP_ADDI, 5'd0, 5'(j), imm), $sformatf("addi load r%0d", j));
        end

        // 2. Register-register ops
        for (int k = 0; k < 80; k++) begin
            r  = nextRand();
            rs = r[7:3];
            rt = (r[23:20] == 4'd0) ? rs : r[12:8];     // Same regs now and then so sub hits 0
            rd = r[17:13];
            runOne(aluInstr(r[2:0], rs, rt, rd), $sformatf("alu op %0d", k));
        end

        // 3. Logical shifts
        for (int k = 0; k < 24; k++) begin
            r  = nextRand();
            fn = r[0] ? `FN_SRL : `FN_SLL;
            runOne(rType(fn, r[5:1], r[10:6], r[15:11], r[20:16]), $sformatf("shift %0d", k));
        end

        // 4. Immediates with some aimed at r0
        for (int k = 0; k < 32; k++) begin
            r = nextRand();
            case (r[1:0])
                2'd0:    op = `OP_ANDI;
                2'd1:    op = `OP_ORI;
                2'd2:    op = `OP_XORI;
                default: op = `OP_SLTI;
            endcase
            rt = (r[4:2] == 3'd0) ? 5'd0 : r[9:5];
            runOne(iType(op, r[14:10], rt, r[31:16]), $sformatf("imm op %0d", k));
        end
        runOne(iType(`OP_ADDI, 5'd0, 5'd0, 16'h0055), "addi to r0");
        runOne(rType(`FN_OR, 5'd0, 5'd0, 5'd0, 5'd0), "r0 reads zero");

        // 5. Dependent chain with a strobe every cycle
        r        = nextRand();
        prevDest = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        for (int k = 0; k < 20; k++) begin
            r  = nextRand();
            rd = (r[9:5] == 5'd0) ? 5'd7 : r[9:5];
            case (r[1:0])
                2'd0:    instr = iType(`OP_ADDI, prevDest, rd, r[31:16]);
                2'd1:    instr = rType(`FN_ADD, prevDest, prevDest, rd, 5'd0);
                2'd2:    instr = rType(`FN_XOR, prevDest, r[14:10], rd, 5'd0);
                default: instr = rType(`FN_SUB, r[14:10], prevDest, rd, 5'd0);
            endcase
            driveInstr(instr);
            checkOutputs($sformatf("back to back %0d", k));
            prevDest = rd;
        end
        instrValid = 1'b0;

        // 6. Illegal encodings change nothing
        for (int k = 0; k < 24; k++) begin
            r = nextRand();
            case (r[1:0])
                2'd0: begin
                    op = r[7:2];
                    if (op == `OP_RTYPE || op == `OP_SPECIAL2 || op == `OP_ADDI ||
                        op == `OP_SLTI || op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI) begin
                        op = 6'h3f;
                    end
                    instr = {op, r[31:6]};
                end
                2'd1: begin
                    fn = r[7:2];
                    if (fn == `FN_SLL || fn == `FN_SRL || fn == `FN_ADD || fn == `FN_SUB ||
                        fn == `FN_AND || fn == `FN_OR || fn == `FN_XOR || fn == `FN_NOR ||
                        fn == `FN_SLT) begin
                        fn = 6'h3f;
                    end
                    instr = rType(fn, r[12:8], r[17:13], r[22:18], r[27:23]);
                end
                default: begin
                    fn = (r[7:2] == `FN_MUL) ? 6'h3f : r[7:2];
                    instr = {`OP_SPECIAL2, r[12:8], r[17:13], r[22:18], 5'd0, fn};
                end
            endcase
            runOne(instr, $sformatf("illegal %0d", k));
        end
        readAllRegs();

        total = resultErrors + zeroErrors + regErrors + flagErrors + timeoutErrors;
        $display("Errors: %0d total (result %0d, zero %0d, destReg %0d, flag %0d, timeout %0d)",
                 total, resultErrors, zeroErrors, regErrors, flagErrors, timeoutErrors);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
